// File: verif/i2s_rx_trace.txt
# op cnt a d, numbers in hex, one operation per line
# wr n waddr dat, clr n addr dat, rd n addr dat, wa 0 waddr 0, push n 0 dat, pop n 0 dat
# pp n pushdat popdat, flush 0 0 0, lvl 0 level flags where flags is empty,full
lvl 0 000 2
wa 0 1ff 0
wr 8 007 a000
rd 8 000 a000
clr 2 003 e000
rd 1 003 0000
rd 1 004 0000
rd 3 000 a000
rd 3 005 a005
wa 0 009 0
wr 2 00b b000
rd 2 00a b000
wr 1f4 1ff c000
wr 1 000 d000
rd 1 000 d000
rd 1 1ff c1f3
rd 1 00c c000
push 4 0 0100
lvl 0 004 0
pop 2 0 0100
lvl 0 002 0
pop 2 0 0102
lvl 0 000 2
push 200 0 1000
lvl 0 200 1
push 1 0 9999
lvl 0 200 1
pop 200 0 1000
lvl 0 000 2
pop 1 0 11ff
lvl 0 000 2
push 3 0 2000
lvl 0 003 0
flush 0 0 0
lvl 0 000 2
push 1 0 3000
pop 1 0 3000
lvl 0 000 2
push 2 0 4000
pp 3 5000 4000
lvl 0 002 0
pop 2 0 5001
lvl 0 000 2

// File: i2s_rx_buffers.f
+incdir+common
common/i2s_rx_pkg.sv
hdl/rx_sample_ram.sv
predeci/predeci_buffer.sv
deci_fifo/deci_rx_fifo.sv
hdl/i2s_rx_buffers.sv
verif/tb_i2s_rx_buffers.sv

// File: Makefile
# Verilator build and run for the i2s receive buffers

SRCS := $(shell grep -v '^+' i2s_rx_buffers.f) common/i2s_rx_defines.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_i2s_rx_buffers: i2s_rx_buffers.f $(SRCS)
	verilator --binary --assert -Wno-fatal -j 0 --top-module tb_i2s_rx_buffers \
		-f i2s_rx_buffers.f -Mdir obj_dir -o Vtb_i2s_rx_buffers

run: obj_dir/Vtb_i2s_rx_buffers verif/i2s_rx_trace.txt
	./obj_dir/Vtb_i2s_rx_buffers > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "tests failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: verif/tb_i2s_rx_buffers.sv
//----------------------------------------------------------
// i2s receive buffers testbench
// replays the trace file against the DUT, checks each result
//----------------------------------------------------------

`timescale 1ns/1ps

`include "i2s_rx_defines.svh"

module tb_i2s_rx_buffers
    import i2s_rx_pkg::*;
();

    logic        WBs_CLK_i = 1'b0;
    logic        WBs_RST_i;
    logic        predeci_wr_i;
    sample_t     predeci_dat_i;
    logic        wb_ram_master_i;
    ram_addr_t   wb_ram_addr_i;
    logic        wb_ram_wen_i;
    ram_addr_t   fir_raddr_i;
    sample_t     fir_rdata_o;
    ram_addr_t   predeci_waddr_o;
    logic        predeci_wena_o;
    logic        deci_push_i;
    sample_t     deci_dat_i;
    logic        deci_pop_i;
    logic        deci_flush_i;
    sample_t     deci_dat_o;
    fifo_level_t deci_level_o;
    logic        deci_empty_o;
    logic        deci_full_o;

    // one entry per trace line
    logic [63:0] op_q[$];
    int          cnt_q[$];
    int          a_q[$];
    int          d_q[$];

    int cycle_cnt   = 0;
    int cycle_limit = 32'h7fffffff;
    int check_cnt   = 0;
    int err_cnt     = 0;
    int pass_cnt    = 0;
    int fail_cnt    = 0;
    bit load_ok;

    // FIFO occupancy expected from the accepted operations
    int exp_lvl     = 0;

    i2s_rx_buffers i2s_rx_buffers_inst (.*);

    // 4 ns clock
    always #2 WBs_CLK_i = ~WBs_CLK_i;

    // run limit, set once the trace is loaded
    always @(posedge WBs_CLK_i)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit)
        begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("tests failed");
            $finish;
        end
    end

    //------------------------------------------------------
    // compare tasks
    //------------------------------------------------------

    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_level(input fifo_level_t got, input fifo_level_t exp,
                               input string what);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input ram_addr_t got, input ram_addr_t exp, input string what);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    //------------------------------------------------------
    // trace loading
    //------------------------------------------------------

    task automatic load_trace(output bit ok);
        int               fd;
        int               n;
        int               total;
        int               cnt;
        int               a;
        int               d;
        logic [8*128-1:0] line_buf;
        logic [63:0]      op;
        ok    = 1'b0;
        total = 0;
        fd    = $fopen("verif/i2s_rx_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file verif/i2s_rx_trace.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line_buf = '0;
                n = $fgets(line_buf, fd);
                // comment and blank lines give fewer than four fields
                if (n > 0 && $sscanf(line_buf, "%s %h %h %h", op, cnt, a, d) == 4)
                begin
                    op_q.push_back(op);
                    cnt_q.push_back(cnt);
                    a_q.push_back(a);
                    d_q.push_back(d);
                    total += cnt + 1;
                end
            end
            $fclose(fd);
            ok = (op_q.size() > 0);
            if (!ok)
            begin
                $display("the trace file holds no operations");
            end
            // reset plus a budget of 8 cycles per operation
            cycle_limit = 16 + 8 * total;
        end
    endtask

    //------------------------------------------------------
    // one trace line
    //------------------------------------------------------

    task automatic run_op(input int idx);
        logic [63:0] op;
        int          cnt;
        int          a;
        int          d;
        int          i;
        int          lvl_start;
        sample_t     exp_word;
        op  = op_q[idx];
        cnt = cnt_q[idx];
        a   = a_q[idx];
        d   = d_q[idx];
        case (op)
            64'("wr"):
            begin
                // back-to-back strobes, enable pulses one cycle later
                for (i = 0; i <= cnt; i++)
                begin
                    @(posedge WBs_CLK_i);
                    predeci_wr_i  <= (i < cnt);
                    predeci_dat_i <= sample_t'(d + i);
                    if (i > 0)
                    begin
                        @(negedge WBs_CLK_i);
                        check_flag(predeci_wena_o, 1'b1, "predeci_wena_o");
                    end
                end
                check_addr(predeci_waddr_o, ram_addr_t'(a), "predeci_waddr_o");
            end
            64'("clr"):
            begin
                @(posedge WBs_CLK_i);
                wb_ram_master_i <= 1'b1;
                for (i = 0; i < cnt; i++)
                begin
                    @(posedge WBs_CLK_i);
                    wb_ram_wen_i  <= 1'b1;
                    wb_ram_addr_i <= ram_addr_t'(a + i);
                    // sample strobes alongside, must be discarded
                    predeci_wr_i  <= 1'b1;
                    predeci_dat_i <= sample_t'(d + i);
                    @(negedge WBs_CLK_i);
                    check_flag(predeci_wena_o, 1'b1, "predeci_wena_o in master mode");
                end
                @(posedge WBs_CLK_i);
                wb_ram_wen_i <= 1'b0;
                predeci_wr_i <= 1'b0;
                // registered i2s enable is high here but masked
                @(negedge WBs_CLK_i);
                check_flag(predeci_wena_o, 1'b0, "predeci_wena_o in master mode");
                @(posedge WBs_CLK_i);
                wb_ram_master_i <= 1'b0;
            end
            64'("rd"):
            begin
                for (i = 0; i <= cnt; i++)
                begin
                    @(posedge WBs_CLK_i);
                    fir_raddr_i <= ram_addr_t'(a + i);
                    if (i > 0)
                    begin
                        @(negedge WBs_CLK_i);
                        check_sample(fir_rdata_o, sample_t'(d + i - 1), "fir_rdata_o");
                    end
                end
            end
            64'("wa"):
            begin
                @(negedge WBs_CLK_i);
                check_addr(predeci_waddr_o, ram_addr_t'(a), "predeci_waddr_o");
            end
            64'("push"):
            begin
                for (i = 0; i < cnt; i++)
                begin
                    @(posedge WBs_CLK_i);
                    deci_push_i <= 1'b1;
                    deci_dat_i  <= sample_t'(d + i);
                    // pushes past the depth are dropped
                    if (exp_lvl < `RAM_DEPTH)
                    begin
                        exp_lvl++;
                    end
                end
                @(posedge WBs_CLK_i);
                deci_push_i <= 1'b0;
            end
            64'("pop"), 64'("pp"):
            begin
                // pp pushes from a while popping
                lvl_start = exp_lvl;
                for (i = 0; i <= cnt; i++)
                begin
                    @(posedge WBs_CLK_i);
                    deci_pop_i  <= (i < cnt);
                    deci_push_i <= (i < cnt) && (op == 64'("pp"));
                    deci_dat_i  <= sample_t'(a + i);
                    if (i > 0)
                    begin
                        @(negedge WBs_CLK_i);
                        // stored words come out first, then the ones pushed alongside
                        if (op == 64'("pp") && i > lvl_start)
                        begin
                            exp_word = sample_t'(a + i - 1 - lvl_start);
                        end
                        else
                        begin
                            exp_word = sample_t'(d + i - 1);
                        end
                        check_sample(deci_dat_o, exp_word, "deci_dat_o");
                    end
                end
                // plain pops stop at empty, pp keeps the level
                if (op == 64'("pop"))
                begin
                    exp_lvl = (exp_lvl > cnt) ? exp_lvl - cnt : 0;
                end
            end
            64'("flush"):
            begin
                @(posedge WBs_CLK_i);
                deci_flush_i <= 1'b1;
                @(posedge WBs_CLK_i);
                deci_flush_i <= 1'b0;
                exp_lvl = 0;
            end
            64'("lvl"):
            begin
                // d holds empty in bit 1, full in bit 0
                @(negedge WBs_CLK_i);
                check_level(deci_level_o, fifo_level_t'(a), "deci_level_o");
                check_flag(deci_empty_o, d[1], "deci_empty_o");
                check_flag(deci_full_o, d[0], "deci_full_o");
            end
            default:
            begin
                err_cnt++;
                $display("trace line %0d holds an unknown operation", idx + 1);
            end
        endcase
    endtask

    //------------------------------------------------------
    // main sequence
    //------------------------------------------------------

    initial
    begin
        int k;
        int errs_before;
        WBs_RST_i       = 1'b1;
        predeci_wr_i    = 1'b0;
        predeci_dat_i   = '0;
        wb_ram_master_i = 1'b0;
        wb_ram_addr_i   = '0;
        wb_ram_wen_i    = 1'b0;
        fir_raddr_i     = '0;
        deci_push_i     = 1'b0;
        deci_dat_i      = '0;
        deci_pop_i      = 1'b0;
        deci_flush_i    = 1'b0;
        load_trace(load_ok);
        if (load_ok)
        begin
            repeat (16) @(posedge WBs_CLK_i);
            WBs_RST_i <= 1'b0;
            for (k = 0; k < op_q.size(); k++)
            begin
                errs_before = err_cnt;
                run_op(k);
                if (err_cnt == errs_before)
                begin
                    pass_cnt++;
                    $display("test %0d: pass", k + 1);
                end
                else
                begin
                    fail_cnt++;
                    $display("test %0d: fail", k + 1);
                end
            end
            $display("summary: %0d run, %0d passed, %0d failed, %0d checks, %0d errors",
                     op_q.size(), pass_cnt, fail_cnt, check_cnt, err_cnt);
        end
        if (load_ok && fail_cnt == 0 && err_cnt == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: hdl/i2s_rx_buffers.sv
//----------------------------------------------------------
// i2s receive buffers, top level
// pre-decimation sample buffer beside the decimated FIFO
//----------------------------------------------------------

`timescale 1ns/1ps

module i2s_rx_buffers
    import i2s_rx_pkg::*;
(
    input  logic        WBs_CLK_i,
    input  logic        WBs_RST_i,

    // pre-decimation buffer
    input  logic        predeci_wr_i,
    input  sample_t     predeci_dat_i,
    input  logic        wb_ram_master_i,
    input  ram_addr_t   wb_ram_addr_i,
    input  logic        wb_ram_wen_i,
    input  ram_addr_t   fir_raddr_i,
    output sample_t     fir_rdata_o,
    output ram_addr_t   predeci_waddr_o,
    output logic        predeci_wena_o,

    // decimated FIFO
    input  logic        deci_push_i,
    input  sample_t     deci_dat_i,
    input  logic        deci_pop_i,
    input  logic        deci_flush_i,
    output sample_t     deci_dat_o,
    output fifo_level_t deci_level_o,
    output logic        deci_empty_o,
    output logic        deci_full_o
);

    // mono samples in, FIR reads out
    predeci_buffer u_predeci_buffer (
        .WBs_CLK_i       (WBs_CLK_i),
        .WBs_RST_i       (WBs_RST_i),
        .predeci_wr_i    (predeci_wr_i),
        .predeci_dat_i   (predeci_dat_i),
        .wb_ram_master_i (wb_ram_master_i),
        .wb_ram_addr_i   (wb_ram_addr_i),
        .wb_ram_wen_i    (wb_ram_wen_i),
        .fir_raddr_i     (fir_raddr_i),
        .fir_rdata_o     (fir_rdata_o),
        .predeci_waddr_o (predeci_waddr_o),
        .predeci_wena_o  (predeci_wena_o)
    );

    // decimator output queue
    deci_rx_fifo u_deci_rx_fifo (
        .WBs_CLK_i    (WBs_CLK_i),
        .WBs_RST_i    (WBs_RST_i),
        .deci_push_i  (deci_push_i),
        .deci_dat_i   (deci_dat_i),
        .deci_pop_i   (deci_pop_i),
        .deci_flush_i (deci_flush_i),
        .deci_dat_o   (deci_dat_o),
        .deci_level_o (deci_level_o),
        .deci_empty_o (deci_empty_o),
        .deci_full_o  (deci_full_o)
    );

endmodule

// File: deci_fifo/deci_rx_fifo.sv
//----------------------------------------------------------
// decimated-sample FIFO
// 512 x 16 synchronous FIFO with flush, level and flags
//----------------------------------------------------------

`timescale 1ns/1ps

`include "i2s_rx_defines.svh"

module deci_rx_fifo
    import i2s_rx_pkg::*;
(
    input  logic        WBs_CLK_i,
    input  logic        WBs_RST_i,

    // push side, from the decimator
    input  logic        deci_push_i,
    input  sample_t     deci_dat_i,

    // pop side and control
    input  logic        deci_pop_i,
    input  logic        deci_flush_i,

    // head word and status
    output sample_t     deci_dat_o,
    output fifo_level_t deci_level_o,
    output logic        deci_empty_o,
    output logic        deci_full_o
);

    ram_addr_t   wr_ptr_q;
    ram_addr_t   rd_ptr_q;
    fifo_level_t level_q;
    fifo_level_t level_nxt;

    logic        push_ok;
    logic        pop_ok;

    logic        pop_q;
    sample_t     dat_hold_q;
    sample_t     ram_rdata;

    //------------------------------------------------------
    // accept logic
    //------------------------------------------------------

    // flags straight from the registered level
    assign deci_empty_o = (level_q == '0);
    assign deci_full_o  = (level_q == fifo_level_t'(`RAM_DEPTH));

    // pops ignored when empty
    assign pop_ok  = deci_pop_i & ~deci_empty_o & ~deci_flush_i;
    // pushes dropped when full, unless a pop frees the slot on the same edge
    // (RAM returns the old word on a same-address read/write)
    assign push_ok = deci_push_i & (~deci_full_o | pop_ok) & ~deci_flush_i;

    // level: hold, add, subtract, hold
    always_comb
    begin
        case ({pop_ok, push_ok})
            2'b01:   level_nxt = level_q + 1'b1;
            2'b10:   level_nxt = level_q - 1'b1;
            default: level_nxt = level_q;
        endcase
    end

    //------------------------------------------------------
    // pointers, level and output hold
    //------------------------------------------------------

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            level_q    <= '0;
            pop_q      <= 1'b0;
            dat_hold_q <= '0;
        end
        else if (deci_flush_i)
        begin
            // back to the reset state
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            level_q    <= '0;
            pop_q      <= 1'b0;
            dat_hold_q <= '0;
        end
        else
        begin
            level_q <= level_nxt;
            pop_q   <= pop_ok;
            if (push_ok)
            begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_ok)
            begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // capture the popped word so it holds after the pointer moves
            if (pop_q)
            begin
                dat_hold_q <= ram_rdata;
            end
        end
    end

    // fresh RAM word in the cycle after a pop, held copy otherwise
    assign deci_dat_o   = pop_q ? ram_rdata : dat_hold_q;
    assign deci_level_o = level_q;

    // storage, read port always addresses the head
    rx_sample_ram u_deci_ram (
        .WBs_CLK_i (WBs_CLK_i),
        .wr_en_i   (push_ok),
        .waddr_i   (wr_ptr_q),
        .wdata_i   (deci_dat_i),
        .raddr_i   (rd_ptr_q),
        .rdata_o   (ram_rdata)
    );

    // level bound, pointer arithmetic relies on it
    a_level_max : assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        level_q <= fifo_level_t'(`RAM_DEPTH))
        else $error("deci FIFO level above depth");

    // pointer distance matches the level modulo the depth
    a_ptr_level : assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        ram_addr_t'(wr_ptr_q - rd_ptr_q) == level_q[`ADDR_W-1:0])
        else $error("deci FIFO pointers disagree with the level");

endmodule

// File: predeci/predeci_buffer.sv
//----------------------------------------------------------
// pre-decimation sample buffer
// auto-incrementing sample writes, register-bus clearing
// of single words, and a FIR read port
//----------------------------------------------------------

`timescale 1ns/1ps

`include "i2s_rx_defines.svh"

module predeci_buffer
    import i2s_rx_pkg::*;
(
    input  logic      WBs_CLK_i,
    input  logic      WBs_RST_i,

    // incoming mono samples
    input  logic      predeci_wr_i,
    input  sample_t   predeci_dat_i,

    // register-bus master mode
    input  logic      wb_ram_master_i,
    input  ram_addr_t wb_ram_addr_i,
    input  logic      wb_ram_wen_i,

    // FIR engine read side
    input  ram_addr_t fir_raddr_i,
    output sample_t   fir_rdata_o,

    // write status
    output ram_addr_t predeci_waddr_o,
    output logic      predeci_wena_o
);

    ram_addr_t i2s_waddr_q;
    logic      i2s_wena_q;
    sample_t   i2s_wdata_q;

    ram_addr_t ram_waddr;
    sample_t   ram_wdata;

    //------------------------------------------------------
    // i2s write path
    //------------------------------------------------------

    // address and enable, advance on every strobe
    // even in master mode, those writes just get dropped by the mux
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            i2s_waddr_q <= ram_addr_t'(`WADDR_RST);
            i2s_wena_q  <= 1'b0;
        end
        else
        begin
            i2s_wena_q <= predeci_wr_i;
            if (predeci_wr_i)
            begin
                // 511 rolls over to 0
                i2s_waddr_q <= i2s_waddr_q + 1'b1;
            end
        end
    end

    // sample register, payload only
    always_ff @(posedge WBs_CLK_i)
    begin
        if (predeci_wr_i)
        begin
            i2s_wdata_q <= predeci_dat_i;
        end
    end

    //------------------------------------------------------
    // write port mux
    //------------------------------------------------------

    // master mode clears words, data forced to zero
    assign ram_waddr      = wb_ram_master_i ? wb_ram_addr_i : i2s_waddr_q;
    assign ram_wdata      = wb_ram_master_i ? '0            : i2s_wdata_q;
    assign predeci_wena_o = wb_ram_master_i ? wb_ram_wen_i  : i2s_wena_q;

    assign predeci_waddr_o = i2s_waddr_q;

    // storage
    rx_sample_ram u_predeci_ram (
        .WBs_CLK_i (WBs_CLK_i),
        .wr_en_i   (predeci_wena_o),
        .waddr_i   (ram_waddr),
        .wdata_i   (ram_wdata),
        .raddr_i   (fir_raddr_i),
        .rdata_o   (fir_rdata_o)
    );

    // a bus clear outside master mode never reaches the RAM
    a_master_wen : assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        wb_ram_wen_i |-> wb_ram_master_i)
        else $error("bus write enable high outside master mode");

endmodule

// File: hdl/rx_sample_ram.sv
//----------------------------------------------------------
// rx sample RAM
// simple dual-port 512 x 16 storage, registered read port
//----------------------------------------------------------

`timescale 1ns/1ps

`include "i2s_rx_defines.svh"

module rx_sample_ram
    import i2s_rx_pkg::*;
(
    input  logic      WBs_CLK_i,

    // write port
    input  logic      wr_en_i,
    input  ram_addr_t waddr_i,
    input  sample_t   wdata_i,

    // read port
    input  ram_addr_t raddr_i,
    output sample_t   rdata_o
);

    // storage array, no reset on contents
    sample_t mem [`RAM_DEPTH];

    // write on the enabled edge
    always_ff @(posedge WBs_CLK_i)
    begin
        if (wr_en_i)
        begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // registered read, one cycle latency
    // same-edge write to raddr_i still returns the old word
    always_ff @(posedge WBs_CLK_i)
    begin
        rdata_o <= mem[raddr_i];
    end

endmodule

// File: common/i2s_rx_pkg.sv
//----------------------------------------------------------
// i2s receive buffers
// sample, address and level types
//----------------------------------------------------------

package i2s_rx_pkg;

`include "i2s_rx_defines.svh"

    //------------------------------------------------------
    // payload and bookkeeping types
    //------------------------------------------------------

    // one mono audio sample
    typedef logic [`SAMPLE_W-1:0] sample_t;

    // address into either 512-word buffer
    typedef logic [`ADDR_W-1:0]   ram_addr_t;

    // FIFO occupancy, 0 to 512
    typedef logic [`LEVEL_W-1:0]  fifo_level_t;

endpackage

// File: common/i2s_rx_defines.svh
//----------------------------------------------------------
// i2s receive buffers
// widths and depths shared by the sample RAM and the FIFO
//----------------------------------------------------------

`ifndef I2S_RX_DEFINES_SVH
`define I2S_RX_DEFINES_SVH

// audio sample width, mono 16-bit
`define SAMPLE_W  16

// words per buffer, pre-decimation RAM and decimated FIFO
`define RAM_DEPTH 512

// address bits for RAM_DEPTH words
`define ADDR_W    9

// one bit wider than ADDR_W so a full count of 512 fits
`define LEVEL_W   10

// write address comes out of reset at the top word,
// first increment wraps it to 0
`define WADDR_RST 511

`endif
